// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module load_unit_tb -o load_unit_sim

out=$(./obj_dir/load_unit_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q '^All checks passed$'; then
    exit 0
else
    exit 1
fi

// File: sim.f
source/lsq_pkg.sv
source/rob_value_board.sv
source/load_queue.sv
source/load_align.sv
source/load_unit.sv
test/tb_clock.sv
test/tb_data_mem.sv
test/load_unit_tb.sv

// File: source/load_align.sv
`timescale 1ns/1ns

module load_align
    import lsq_pkg::*;
(
    input  load_funct_e  funct3,
    input  logic [1:0]   addr_low,
    input  word_t        rdata,
    output word_t        result
);

    logic [7:0]   byte_lane;
    logic [15:0]  half_lane;

    // byte lane picked by both low bits
    always_comb begin
        case (addr_low)
            2'b00:   byte_lane = rdata[7:0];
            2'b01:   byte_lane = rdata[15:8];
            2'b10:   byte_lane = rdata[23:16];
            default: byte_lane = rdata[31:24];
        endcase
    end

    // halfword lane only looks at bit 1
    assign half_lane = addr_low[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (funct3)
            lb: begin
                result = {{24{byte_lane[7]}}, byte_lane};
            end
            lh: begin
                result = {{16{half_lane[15]}}, half_lane};
            end
            lbu: begin
                result = {24'h000000, byte_lane};
            end
            lhu: begin
                result = {16'h0000, half_lane};
            end
            default: begin
                // lw, whole word
                result = rdata;
            end
        endcase
    end

endmodule

// File: source/load_queue.sv
`timescale 1ns/1ns

module load_queue
    import lsq_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load,
    input  load_funct_e           funct3,
    input  word_t                 base_data,
    input  rob_tag_t              base_tag,
    input  logic                  base_valid,
    input  word_t                 offset,
    input  rob_tag_t              rd_tag,
    input  logic                  flush_ip,
    input  logic                  cdb_valid,
    input  rob_tag_t              cdb_tag,
    input  word_t                 cdb_data,
    input  logic [ROB_SIZE-1:0]   calculated,
    input  word_t [ROB_SIZE-1:0]  values,
    input  logic                  data_mem_resp,
    output logic                  full,
    output logic                  accept,
    output logic                  flush_clear,
    output logic                  data_read,
    output word_t                 data_mem_address,
    output logic                  finished_entry,
    output rob_tag_t              finished_tag,
    output load_funct_e           head_funct3
);

    lq_state_e   state;
    lq_state_e   next_state;
    lq_ptr_t     head;
    lq_ptr_t     tail;
    lq_count_t   count;
    lq_count_t   count_next;

    // entry storage
    load_funct_e            e_funct3 [LQ_DEPTH];
    word_t                  e_base [LQ_DEPTH];
    rob_tag_t               e_base_tag [LQ_DEPTH];
    word_t                  e_offset [LQ_DEPTH];
    rob_tag_t               e_rd_tag [LQ_DEPTH];
    logic [LQ_DEPTH-1:0]    e_ready;

    logic   serving;
    logic   read_pending;
    logic   retire;
    logic   alloc_hit;
    logic   alloc_ready;
    word_t  alloc_base;

    // base operand for the entry being allocated this cycle
    always_comb begin
        alloc_hit   = cdb_valid && (cdb_tag == base_tag);
        alloc_ready = base_valid || calculated[base_tag] || alloc_hit;
        if (base_valid) begin
            alloc_base = base_data;
        end else if (alloc_hit) begin
            alloc_base = cdb_data;
        end else begin
            alloc_base = values[base_tag];
        end
    end

    assign serving = (state == lq_active) || (state == lq_full);
    assign full    = (state == lq_reset) || (state == lq_full) || (state == lq_flush);
    assign accept  = load && !full;

    // read level holds on the head entry until the response
    assign data_read        = (serving && e_ready[head]) || (state == lq_flush);
    assign data_mem_address = e_base[head] + e_offset[head];
    assign read_pending     = data_read && !data_mem_resp;
    assign retire           = serving && data_read && data_mem_resp;

    // a load flushed in its own response cycle is not reported
    assign finished_entry = retire && !flush_ip;
    assign finished_tag   = e_rd_tag[head];
    assign head_funct3    = e_funct3[head];

    always_comb begin
        flush_clear = 1'b0;
        if (state == lq_flush) begin
            flush_clear = data_mem_resp;
        end else if (state != lq_reset) begin
            flush_clear = flush_ip && !read_pending;
        end
    end

    assign count_next = count + lq_count_t'(accept) - lq_count_t'(retire);

    always_comb begin
        next_state = state;
        case (state)
            lq_reset: begin
                next_state = lq_idle;
            end
            lq_flush: begin
                if (data_mem_resp) begin
                    next_state = lq_idle;
                end
            end
            default: begin
                if (flush_ip && read_pending) begin
                    next_state = lq_flush;
                end else if (flush_clear || (count_next == '0)) begin
                    next_state = lq_idle;
                end else if (count_next == lq_count_t'(LQ_DEPTH)) begin
                    next_state = lq_full;
                end else begin
                    next_state = lq_active;
                end
            end
        endcase
    end

    // control state
    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= lq_reset;
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            e_ready <= '0;
        end else begin
            state <= next_state;
            if (flush_clear) begin
                head    <= '0;
                tail    <= '0;
                count   <= '0;
                e_ready <= '0;
            end else begin
                count <= count_next;
                for (int i = 0; i < LQ_DEPTH; i++) begin
                    if (!e_ready[i] && cdb_valid && (cdb_tag == e_base_tag[i])) begin
                        e_ready[i] <= 1'b1;
                    end
                end
                if (retire) begin
                    head <= head + 1'b1;
                end
                if (accept) begin
                    e_ready[tail] <= alloc_ready;
                    tail          <= tail + 1'b1;
                end
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < LQ_DEPTH; i++) begin
            if (!e_ready[i] && cdb_valid && (cdb_tag == e_base_tag[i])) begin
                e_base[i] <= cdb_data;
            end
        end
        if (accept) begin
            e_funct3[tail]   <= funct3;
            e_base[tail]     <= alloc_base;
            e_base_tag[tail] <= base_tag;
            e_offset[tail]   <= offset;
            e_rd_tag[tail]   <= rd_tag;
        end
    end

endmodule

// File: source/load_unit.sv
`timescale 1ns/1ns

module load_unit
    import lsq_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         load,
    input  load_funct_e  funct3,
    input  word_t        base_data,
    input  rob_tag_t     base_tag,
    input  logic         base_valid,
    input  word_t        offset,
    input  rob_tag_t     rd_tag,
    input  logic         flush_ip,
    input  logic         cdb_valid,
    input  rob_tag_t     cdb_tag,
    input  word_t        cdb_data,
    input  logic         data_mem_resp,
    input  word_t        data_mem_rdata,
    output logic         full,
    output logic         data_read,
    output word_t        data_mem_address,
    output logic         finished_entry,
    output rob_tag_t     finished_tag,
    output word_t        finished_data
);

    logic [ROB_SIZE-1:0]   calculated;
    word_t [ROB_SIZE-1:0]  values;
    logic                  accept;
    logic                  flush_clear;
    load_funct_e           head_funct3;

    rob_value_board board (
        .clk        (clk),
        .rst        (rst),
        .cdb_valid  (cdb_valid),
        .cdb_tag    (cdb_tag),
        .cdb_data   (cdb_data),
        .alloc      (accept),
        .alloc_tag  (rd_tag),
        .flush      (flush_clear),
        .calculated (calculated),
        .values     (values)
    );

    load_queue queue (
        .clk              (clk),
        .rst              (rst),
        .load             (load),
        .funct3           (funct3),
        .base_data        (base_data),
        .base_tag         (base_tag),
        .base_valid       (base_valid),
        .offset           (offset),
        .rd_tag           (rd_tag),
        .flush_ip         (flush_ip),
        .cdb_valid        (cdb_valid),
        .cdb_tag          (cdb_tag),
        .cdb_data         (cdb_data),
        .calculated       (calculated),
        .values           (values),
        .data_mem_resp    (data_mem_resp),
        .full             (full),
        .accept           (accept),
        .flush_clear      (flush_clear),
        .data_read        (data_read),
        .data_mem_address (data_mem_address),
        .finished_entry   (finished_entry),
        .finished_tag     (finished_tag),
        .head_funct3      (head_funct3)
    );

    // result lane comes from the head address, which is still on the bus
    load_align align (
        .funct3   (head_funct3),
        .addr_low (data_mem_address[1:0]),
        .rdata    (data_mem_rdata),
        .result   (finished_data)
    );

endmodule

// File: source/lsq_pkg.sv
package lsq_pkg;

    // queue and ROB sizing
    localparam int LQ_DEPTH = 4;
    localparam int ROB_SIZE = 8;

    // data and address words are both 32 bits on RV32I
    typedef logic [31:0] word_t;

    typedef logic [$clog2(ROB_SIZE)-1:0] rob_tag_t;

    // pointers wrap naturally since the depth is a power of two
    typedef logic [$clog2(LQ_DEPTH)-1:0] lq_ptr_t;

    // occupancy needs one more bit than a pointer to reach LQ_DEPTH
    typedef logic [$clog2(LQ_DEPTH):0] lq_count_t;

    // funct3 encodings of the RV32I load group
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct_e;

    // queue control states
    typedef enum logic [2:0] {
        lq_reset  = 3'd0,
        lq_idle   = 3'd1,
        lq_active = 3'd2,
        lq_full   = 3'd3,
        lq_flush  = 3'd4
    } lq_state_e;

endpackage

// File: source/rob_value_board.sv
`timescale 1ns/1ns

module rob_value_board
    import lsq_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cdb_valid,
    input  rob_tag_t                  cdb_tag,
    input  word_t                     cdb_data,
    input  logic                      alloc,
    input  rob_tag_t                  alloc_tag,
    input  logic                      flush,
    output logic [ROB_SIZE-1:0]       calculated,
    output word_t [ROB_SIZE-1:0]      values
);

    // one calculated flag per tag
    always_ff @(posedge clk) begin
        if (!rst) begin
            calculated <= '0;
        end else if (flush) begin
            calculated <= '0;
        end else begin
            if (cdb_valid) begin
                calculated[cdb_tag] <= 1'b1;
            end
            // a new load reuses its rd tag, so the old result is stale
            // this assignment comes last so it beats a same-cycle broadcast
            if (alloc) begin
                calculated[alloc_tag] <= 1'b0;
            end
        end
    end

    // broadcast values only mean something while the flag is set
    always_ff @(posedge clk) begin
        if (cdb_valid) begin
            values[cdb_tag] <= cdb_data;
        end
    end

endmodule

// File: test/load_unit_tb.sv
`timescale 1ns/1ns

module load_unit_tb
    import lsq_pkg::*;
();

    localparam int ref_size = 64;

    logic         clk;
    logic         rst;
    logic         load;
    load_funct_e  funct3;
    word_t        base_data;
    rob_tag_t     base_tag;
    logic         base_valid;
    word_t        offset;
    rob_tag_t     rd_tag;
    logic         flush_ip;
    logic         cdb_valid;
    rob_tag_t     cdb_tag;
    word_t        cdb_data;
    logic         data_mem_resp;
    word_t        data_mem_rdata;
    logic         full;
    logic         data_read;
    word_t        data_mem_address;
    logic         finished_entry;
    rob_tag_t     finished_tag;
    word_t        finished_data;

    // reference queue written at dispatch and read in order
    word_t        exp_addr [ref_size];
    word_t        exp_data [ref_size];
    rob_tag_t     exp_tag [ref_size];
    int           exp_btag [ref_size];
    logic         exp_ready [ref_size];
    int           wr_idx = 0;
    int           rd_idx = 0;
    logic         flushing = 1'b0;
    load_funct_e  funct_list [5] = '{lb, lh, lw, lbu, lhu};

    tb_clock clock_gen (
        .clk (clk),
        .rst (rst)
    );

    tb_data_mem mem (
        .clk     (clk),
        .rst     (rst),
        .read    (data_read),
        .address (data_mem_address),
        .resp    (data_mem_resp),
        .rdata   (data_mem_rdata)
    );

    load_unit dut (.*);

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1);
    endtask

    // byte and halfword lanes found by shifting the word down
    function automatic word_t expected_load(input word_t w, input load_funct_e f,
                                            input logic [1:0] low);
        word_t bsel;
        word_t hsel;
        bsel = w >> {low, 3'b000};
        hsel = w >> {low[1], 4'b0000};
        case (f)
            lb:      return {{24{bsel[7]}}, bsel[7:0]};
            lbu:     return {24'd0, bsel[7:0]};
            lh:      return {{16{hsel[15]}}, hsel[15:0]};
            lhu:     return {16'd0, hsel[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // known means a valid base at dispatch
    // bypass puts the base tag on the CDB in the same cycle
    task automatic dispatch(input load_funct_e f, input word_t base, input int btag,
                            input logic known, input logic bypass, input word_t off,
                            input rob_tag_t rd);
        word_t addr;
        int guard;
        guard = 0;
        while (full) begin
            next_cycle();
            guard++;
            if (guard > 50) begin
                stop_with_failure("timeout: the queue never accepted a load");
            end
        end
        addr              = base + off;
        exp_addr[wr_idx]  = addr;
        exp_data[wr_idx]  = expected_load(mem.words[addr[7:2]], f, addr[1:0]);
        exp_tag[wr_idx]   = rd;
        exp_btag[wr_idx]  = known ? -1 : btag;
        exp_ready[wr_idx] = known || bypass;
        wr_idx++;
        load       = 1'b1;
        funct3     = f;
        base_data  = known ? base : 32'hdead_beef;
        base_tag   = rob_tag_t'(btag);
        base_valid = known;
        offset     = off;
        rd_tag     = rd;
        cdb_valid  = bypass;
        cdb_tag    = rob_tag_t'(btag);
        cdb_data   = base;
        next_cycle();
        load       = 1'b0;
        base_valid = 1'b0;
        cdb_valid  = 1'b0;
    endtask

    task automatic broadcast(input rob_tag_t tag, input word_t value);
        for (int i = rd_idx; i < wr_idx; i++) begin
            if (exp_btag[i] == int'(tag)) begin
                exp_ready[i] = 1'b1;
            end
        end
        cdb_valid = 1'b1;
        cdb_tag   = tag;
        cdb_data  = value;
        next_cycle();
        cdb_valid = 1'b0;
    endtask

    task automatic drain();
        int guard;
        guard = 0;
        while ((rd_idx != wr_idx) || data_read) begin
            next_cycle();
            guard++;
            if (guard > 200) begin
                stop_with_failure("timeout: outstanding loads never finished");
            end
        end
    endtask

    task automatic wait_for_outstanding_read();
        int guard;
        guard = 0;
        while (!(data_read && !data_mem_resp)) begin
            next_cycle();
            guard++;
            if (guard > 50) begin
                stop_with_failure("timeout: no read was started");
            end
        end
    endtask

    // reference queue bookkeeping
    always @(posedge clk) begin
        if (flush_ip) begin
            rd_idx   <= wr_idx;
            flushing <= data_read && !data_mem_resp;
        end else if (flushing && data_mem_resp) begin
            flushing <= 1'b0;
        end else if (finished_entry) begin
            rd_idx <= rd_idx + 1;
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !$past(rst) |-> !data_read && !finished_entry)
        else stop_with_failure($sformatf("ERR %0t: read or finish active in reset", $time));

    a_full_first: assert property (@(posedge clk) (rst && !$past(rst)) |-> full)
        else stop_with_failure($sformatf("ERR %0t: full low in first cycle", $time));

    a_full_count: assert property (@(posedge clk)
        (rst && $past(rst) && !flushing) |-> full == ((wr_idx - rd_idx - int'(load)) == LQ_DEPTH))
        else stop_with_failure($sformatf("ERR %0t: full is %0b, wrong for occupancy", $time, full));

    a_read_addr: assert property (@(posedge clk) (data_read && !flushing) |->
        (rd_idx != wr_idx) && exp_ready[rd_idx] && (data_mem_address == exp_addr[rd_idx]))
        else stop_with_failure($sformatf("ERR %0t: read at %h, unexpected", $time,
                                         data_mem_address));

    a_addr_stable: assert property (@(posedge clk)
        (data_read && $past(data_read) && !$past(data_mem_resp)) |-> $stable(data_mem_address))
        else stop_with_failure($sformatf("ERR %0t: address moved during a read", $time));

    a_finish: assert property (@(posedge clk) finished_entry |-> (rd_idx != wr_idx) &&
        (finished_tag == exp_tag[rd_idx]) && (finished_data == exp_data[rd_idx]))
        else stop_with_failure($sformatf("ERR %0t: finished tag %0d data %h, expected %0d %h",
                                         $time, finished_tag, finished_data,
                                         exp_tag[rd_idx], exp_data[rd_idx]));

    a_flush_drop: assert property (@(posedge clk) flushing |-> data_read && !finished_entry)
        else stop_with_failure($sformatf("ERR %0t: read dropped or result reported in flush",
                                         $time));

    a_flush_exit: assert property (@(posedge clk) (!flushing && $past(flushing)) |-> !full)
        else stop_with_failure($sformatf("ERR %0t: full still high after flush", $time));

    initial begin
        int guard;
        load       = 1'b0;
        funct3     = lw;
        base_data  = '0;
        base_tag   = '0;
        base_valid = 1'b0;
        offset     = '0;
        rd_tag     = '0;
        flush_ip   = 1'b0;
        cdb_valid  = 1'b0;
        cdb_tag    = '0;
        cdb_data   = '0;
        guard      = 0;
        while (!rst) begin
            next_cycle();
            guard++;
            if (guard > 20) begin
                stop_with_failure("timeout: reset was never released");
            end
        end
        next_cycle();
        next_cycle();

        // every funct3 on every lane dispatched back to back so the queue fills
        for (int lane = 0; lane < 4; lane++) begin
            for (int k = 0; k < 5; k++) begin
                dispatch(funct_list[k], word_t'(32'h20 * k + 32'h10), 0, 1'b1, 1'b0,
                         word_t'(lane + 4), rob_tag_t'(lane * 5 + k));
            end
        end
        drain();

        // base waits on tag 5 and then a bypassed tag 6
        dispatch(lh, 32'h64, 5, 1'b0, 1'b0, 32'h6, 3'd1);
        repeat (3) next_cycle();
        broadcast(3'd5, 32'h64);
        dispatch(lbu, 32'h31, 6, 1'b0, 1'b1, 32'h2, 3'd2);
        drain();

        // flush while nothing is being read
        dispatch(lw, 32'h10, 7, 1'b0, 1'b0, 32'h0, 3'd3);
        dispatch(lb, 32'h20, 7, 1'b0, 1'b0, 32'h1, 3'd4);
        next_cycle();
        flush_ip = 1'b1;
        next_cycle();
        flush_ip = 1'b0;
        broadcast(3'd7, 32'h10);
        repeat (4) next_cycle();

        // flush with a read outstanding
        dispatch(lw, 32'h80, 0, 1'b1, 1'b0, 32'h8, 3'd5);
        dispatch(lhu, 32'h84, 0, 1'b1, 1'b0, 32'h2, 3'd6);
        wait_for_outstanding_read();
        flush_ip = 1'b1;
        next_cycle();
        flush_ip = 1'b0;
        dispatch(lh, 32'h50, 0, 1'b1, 1'b0, 32'h2, 3'd7);
        dispatch(lb, 32'h50, 0, 1'b1, 1'b0, 32'h3, 3'd0);
        drain();

        $display("All checks passed");
        $finish;
    end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst
);

    localparam int half_period = 10;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // reset held for four edges and released with the other stimulus
    initial begin
        rst = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b1;
    end

endmodule

// File: test/tb_data_mem.sv
`timescale 1ns/1ns

module tb_data_mem
    import lsq_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   read,
    input  word_t  address,
    output logic   resp,
    output word_t  rdata
);

    localparam logic [31:0] seed = 32'h2a7c713d;
    localparam int depth = 64;

    word_t        words [depth];
    logic [31:0]  rand_state;
    logic         busy;
    int           wait_cnt;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        resp       = 1'b0;
        rdata      = '0;
        busy       = 1'b0;
        wait_cnt   = 0;
        rand_state = seed;
        // one step of the sequence per word address of the 256 byte space
        for (int i = 0; i < depth; i++) begin
            rand_state = xorshift32(rand_state);
            words[i]   = rand_state;
        end
        // outputs move 1 ns after the edge and ahead of the other stimulus
        forever begin
            @(posedge clk);
            #1;
            resp = 1'b0;
            if (!rst) begin
                busy = 1'b0;
            end else if (busy) begin
                if (wait_cnt == 0) begin
                    resp  = 1'b1;
                    rdata = words[address[7:2]];
                    busy  = 1'b0;
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end else if (read) begin
                // latency of 1 to 4 cycles
                rand_state = xorshift32(rand_state);
                wait_cnt   = int'(rand_state[1:0]);
                busy       = 1'b1;
            end
        end
    end

endmodule
